//--- hdl/accelBridgePkg.sv
package accelBridgePkg;

	// ==========================================================
	// bus and data widths
	// ==========================================================

	typedef logic [31:0] fifoWord_t;		// one word on either FIFO
	typedef logic [31:0] cmdId_t;			// command id as sent by the host
	typedef logic signed [7:0] accelSample_t;	// raw filtered accel reading
	typedef logic [7:0] magnitude_t;		// abs value, -128 maps to 128
	typedef logic [31:0] accelSum_t;		// running total of magnitudes

	// accelerometer sum command
	localparam cmdId_t CMD_ACCEL = 32'd10;

	// ==========================================================
	// state machines
	// ==========================================================

	// host FIFO reader, one word per pass
	typedef enum logic [1:0] {
		RD_IDLE,	// wait for data and a free sequencer
		RD_READ,	// inRead high
		RD_WAIT		// gap after the pop
	} readerState_t;

	typedef enum logic [1:0] {
		SM_IDLE,
		SM_ARM,		// looking for the trigger sample
		SM_SUM,		// adding the window
		SM_DONE		// result held until request drops
	} summerState_t;

	typedef enum logic [2:0] {
		SQ_IDLE,
		SQ_ACCEL_REQ,	// summer running
		SQ_ACCEL_DROP,	// wait for done to fall
		SQ_RESP,	// wait for a free writer
		SQ_HANDOFF	// respValid cycle
	} seqState_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_WAIT,	// holding word until outFull low
		WR_PULSE,	// outWrite high
		WR_GAP		// idle after a write
	} writerState_t;

endpackage

//--- hdl/hpsCommandReader.sv
`timescale 1ns/1ps

module hpsCommandReader
	import accelBridgePkg::*;
(
	input  logic      CLOCK_50,
	input  logic      master_reset,
	input  logic      inEmpty,
	input  fifoWord_t inData,
	input  logic      seqBusy,
	output logic      inRead,
	output logic      cmdValid,
	output cmdId_t    cmdId
);

	readerState_t state;
	logic payloadPending;	// accel id seen, one word left to drop

	// ==========================================================
	// host FIFO read machine
	// ==========================================================
	// show-ahead FIFO, head word sits on inData during inRead
	always_ff @(posedge CLOCK_50) begin
		if (master_reset) begin
			state <= RD_IDLE;
			inRead <= 1'b0;
			cmdValid <= 1'b0;
			payloadPending <= 1'b0;
		end else begin
			cmdValid <= 1'b0;	// one cycle strobe
			case (state)
				RD_IDLE: begin
					// hold off while a command is still being served
					if (!inEmpty && !seqBusy) begin
						inRead <= 1'b1;
						state <= RD_READ;
					end
				end
				RD_READ: begin
					inRead <= 1'b0;	// word popped at this edge
					state <= RD_WAIT;
					if (!payloadPending) begin
						cmdId <= inData;	// first word is the id
						if (inData == CMD_ACCEL) begin
							payloadPending <= 1'b1;	// dummy word follows
						end else begin
							cmdValid <= 1'b1;	// unknown id, no payload
						end
					end else begin
						// accel payload carries nothing, thrown away
						payloadPending <= 1'b0;
						cmdValid <= 1'b1;
					end
				end
				RD_WAIT: begin
					state <= RD_IDLE;	// second idle cycle is spent in RD_IDLE
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/accelSampleSummer.sv
`timescale 1ns/1ps

module accelSampleSummer
	import accelBridgePkg::*;
#(
	parameter int SAMPLE_COUNT = 50,
	parameter int TRIGGER_LEVEL = 16
) (
	input  logic         CLOCK_50,
	input  logic         master_reset,
	input  accelSample_t accelSample,
	input  logic         sampleStrobe,
	input  logic         accelRequest,
	output logic         accelDone,
	output accelSum_t    accelTotal
);

	localparam int COUNT_W = $clog2(SAMPLE_COUNT + 1);

	summerState_t state;
	magnitude_t magnitude;
	logic [COUNT_W-1:0] sampleCount;	// strobed samples taken so far
	logic triggerHit;
	logic lastSample;

	// abs value of the reading
	always_comb begin
		if (accelSample[7]) begin
			magnitude = magnitude_t'(-accelSample);	// 8'h80 stays 8'h80, i.e. 128
		end else begin
			magnitude = magnitude_t'(accelSample);
		end
	end

	assign triggerHit = sampleStrobe && (magnitude >= magnitude_t'(TRIGGER_LEVEL));
	assign lastSample = (sampleCount == COUNT_W'(SAMPLE_COUNT - 1));

	// ==========================================================
	// trigger, window and result hold
	// ==========================================================
	always_ff @(posedge CLOCK_50) begin
		if (master_reset) begin
			state <= SM_IDLE;
			accelDone <= 1'b0;
		end else begin
			case (state)
				SM_IDLE: begin
					accelDone <= 1'b0;
					sampleCount <= '0;	// fresh window per request
					accelTotal <= '0;
					if (accelRequest) begin
						state <= SM_ARM;
					end
				end
				SM_ARM: begin
					// trigger sample itself is not summed
					if (triggerHit) begin
						state <= SM_SUM;
					end
				end
				SM_SUM: begin
					if (sampleStrobe) begin
						accelTotal <= accelTotal + accelSum_t'(magnitude);
						sampleCount <= sampleCount + 1'b1;
						if (lastSample) begin
							accelDone <= 1'b1;	// window complete
							state <= SM_DONE;
						end
					end
				end
				SM_DONE: begin
					if (!accelRequest) begin
						accelDone <= 1'b0;	// falls the cycle after request drops
						state <= SM_IDLE;
					end
				end
				default: begin
					state <= SM_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/commandSequencer.sv
`timescale 1ns/1ps

module commandSequencer
	import accelBridgePkg::*;
(
	input  logic      CLOCK_50,
	input  logic      master_reset,
	input  logic      cmdValid,
	input  cmdId_t    cmdId,
	input  logic      accelDone,
	input  accelSum_t accelTotal,
	input  logic      writerBusy,
	output logic      seqBusy,
	output logic      accelRequest,
	output logic      respValid,
	output cmdId_t    respCmd,
	output fifoWord_t respData
);

	seqState_t state;

	// reader stays off the FIFO until the response is handed over
	assign seqBusy = (state != SQ_IDLE);

	// ==========================================================
	// command dispatch
	// ==========================================================
	always_ff @(posedge CLOCK_50) begin
		if (master_reset) begin
			state <= SQ_IDLE;
			accelRequest <= 1'b0;
			respValid <= 1'b0;
		end else begin
			respValid <= 1'b0;	// single cycle handoff
			case (state)
				SQ_IDLE: begin
					if (cmdValid) begin
						respCmd <= cmdId;	// id echoed as first word
						if (cmdId == CMD_ACCEL) begin
							accelRequest <= 1'b1;
							state <= SQ_ACCEL_REQ;
						end else begin
							respData <= '0;	// unknown id answers zero
							if (!writerBusy) begin
								respValid <= 1'b1;
								state <= SQ_HANDOFF;
							end else begin
								state <= SQ_RESP;
							end
						end
					end
				end
				SQ_ACCEL_REQ: begin
					if (accelDone) begin
						respData <= accelTotal;	// latch result
						accelRequest <= 1'b0;
						state <= SQ_ACCEL_DROP;
					end
				end
				SQ_ACCEL_DROP: begin
					// summer back in idle once done falls
					if (!accelDone) begin
						state <= SQ_RESP;
					end
				end
				SQ_RESP: begin
					if (!writerBusy) begin
						respValid <= 1'b1;
						state <= SQ_HANDOFF;
					end
				end
				SQ_HANDOFF: begin
					state <= SQ_IDLE;	// writer has captured it
				end
				default: begin
					state <= SQ_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/hpsResponseWriter.sv
`timescale 1ns/1ps

module hpsResponseWriter
	import accelBridgePkg::*;
(
	input  logic      CLOCK_50,
	input  logic      master_reset,
	input  logic      respValid,
	input  cmdId_t    respCmd,
	input  fifoWord_t respData,
	input  logic      outFull,
	output logic      writerBusy,
	output logic      outWrite,
	output fifoWord_t outData
);

	writerState_t state;
	cmdId_t cmdHold;	// captured response
	fifoWord_t dataHold;
	logic wordSel;		// 0 id word, 1 result word

	assign writerBusy = (state != WR_IDLE);

	// ==========================================================
	// FPGA to host FIFO write machine
	// ==========================================================
	always_ff @(posedge CLOCK_50) begin
		if (master_reset) begin
			state <= WR_IDLE;
			outWrite <= 1'b0;
			wordSel <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (respValid) begin
						cmdHold <= respCmd;
						dataHold <= respData;
						wordSel <= 1'b0;	// id goes out first
						state <= WR_WAIT;
					end
				end
				WR_WAIT: begin
					// back-pressure, no timeout
					if (!outFull) begin
						outData <= wordSel ? dataHold : fifoWord_t'(cmdHold);
						outWrite <= 1'b1;
						state <= WR_PULSE;
					end
				end
				WR_PULSE: begin
					outWrite <= 1'b0;	// taken at this edge
					state <= WR_GAP;
				end
				WR_GAP: begin
					if (wordSel) begin
						state <= WR_IDLE;	// both words gone
					end else begin
						wordSel <= 1'b1;
						state <= WR_WAIT;
					end
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/accelCommandBridge.sv
`timescale 1ns/1ps

module accelCommandBridge
	import accelBridgePkg::*;
#(
	parameter int SAMPLE_COUNT = 50,	// samples summed after the trigger
	parameter int TRIGGER_LEVEL = 16	// min magnitude that starts a window
) (
	input  logic         CLOCK_50,
	input  logic         master_reset,
	input  logic         inEmpty,
	output logic         inRead,
	input  fifoWord_t    inData,
	input  logic         outFull,
	output logic         outWrite,
	output fifoWord_t    outData,
	input  accelSample_t accelSample,
	input  logic         sampleStrobe
);

	// ==========================================================
	// block to block wiring
	// ==========================================================
	logic cmdValid;		// reader to sequencer
	cmdId_t cmdId;
	logic seqBusy;
	logic accelRequest;	// sequencer and summer handshake
	logic accelDone;
	accelSum_t accelTotal;
	logic respValid;	// sequencer to writer
	cmdId_t respCmd;
	fifoWord_t respData;
	logic writerBusy;

	hpsCommandReader commandReader (
		.CLOCK_50     (CLOCK_50),
		.master_reset (master_reset),
		.inEmpty      (inEmpty),
		.inData       (inData),
		.seqBusy      (seqBusy),
		.inRead       (inRead),
		.cmdValid     (cmdValid),
		.cmdId        (cmdId)
	);

	commandSequencer sequencer (
		.CLOCK_50     (CLOCK_50),
		.master_reset (master_reset),
		.cmdValid     (cmdValid),
		.cmdId        (cmdId),
		.accelDone    (accelDone),
		.accelTotal   (accelTotal),
		.writerBusy   (writerBusy),
		.seqBusy      (seqBusy),
		.accelRequest (accelRequest),
		.respValid    (respValid),
		.respCmd      (respCmd),
		.respData     (respData)
	);

	// sample window parameters set here only
	accelSampleSummer #(
		.SAMPLE_COUNT  (SAMPLE_COUNT),
		.TRIGGER_LEVEL (TRIGGER_LEVEL)
	) sampleSummer (
		.CLOCK_50     (CLOCK_50),
		.master_reset (master_reset),
		.accelSample  (accelSample),
		.sampleStrobe (sampleStrobe),
		.accelRequest (accelRequest),
		.accelDone    (accelDone),
		.accelTotal   (accelTotal)
	);

	hpsResponseWriter responseWriter (
		.CLOCK_50     (CLOCK_50),
		.master_reset (master_reset),
		.respValid    (respValid),
		.respCmd      (respCmd),
		.respData     (respData),
		.outFull      (outFull),
		.writerBusy   (writerBusy),
		.outWrite     (outWrite),
		.outData      (outData)
	);

endmodule

//--- bench/accelCommandBridge_checker.sv
`timescale 1ns/1ps

module accelCommandBridge_checker (
	input logic CLOCK_50,
	input logic master_reset,
	input logic inEmpty,
	input logic inRead,
	input logic outFull,
	input logic outWrite
);

	// ==========================================================
	// FIFO strobe rules
	// ==========================================================
	readPulseWidth: assert property (@(posedge CLOCK_50) disable iff (master_reset)
		inRead |=> !inRead)
		else $error("inRead stayed high for more than one cycle");

	writePulseWidth: assert property (@(posedge CLOCK_50) disable iff (master_reset)
		outWrite |=> !outWrite)
		else $error("outWrite stayed high for more than one cycle");

	// pop only after the FIFO showed data
	readNeedsData: assert property (@(posedge CLOCK_50) disable iff (master_reset)
		inRead |-> $past(!inEmpty))
		else $error("inRead issued without inEmpty low the cycle before");

	writeNeedsRoom: assert property (@(posedge CLOCK_50) disable iff (master_reset)
		outWrite |-> $past(!outFull))	// back-pressure honoured
		else $error("outWrite issued without outFull low the cycle before");

endmodule

bind accelCommandBridge accelCommandBridge_checker strobeChecks (
	.CLOCK_50     (CLOCK_50),
	.master_reset (master_reset),
	.inEmpty      (inEmpty),
	.inRead       (inRead),
	.outFull      (outFull),
	.outWrite     (outWrite)
);

//--- bench/accelCommandBridge_tb.sv
`timescale 1ns/1ps

module accelCommandBridge_tb
	import accelBridgePkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam int MODE_RANDOM = 0;		// full range strobed samples
	localparam int MODE_QUIET = 1;		// first 12 strobes below trigger
	localparam int MODE_EXTREME = 2;	// -128, 127, -16, 15 only
	localparam int BP_NONE = 0;
	localparam int BP_PULSED = 1;		// outFull high 2 of 5 cycles
	localparam int BP_LONG = 2;		// outFull high 11 of 16 cycles

	logic CLOCK_50;
	logic master_reset;
	logic inEmpty;
	logic inRead;
	fifoWord_t inData;
	logic outFull;
	logic outWrite;
	fifoWord_t outData;
	accelSample_t accelSample;
	logic sampleStrobe;

	// stimulus table, one entry per row
	string rowName [NUM_ROWS];
	cmdId_t rowId [NUM_ROWS];
	fifoWord_t rowPayload [NUM_ROWS];
	int rowMode [NUM_ROWS];
	int rowBp [NUM_ROWS];
	logic rowQueued [NUM_ROWS];	// next row shares the FIFO fill

	fifoWord_t hostQ [$];		// host to FPGA FIFO
	fifoWord_t respQ [$];		// words the DUT wrote
	int armPops [$];		// pop number of each accel payload word
	int armModes [$];
	accelSum_t expSums [$];		// reference window sums
	int pushCount;
	int popCount;
	int cycleCount;
	int bpMode;
	logic readSeen;			// inRead seen, pop at next falling edge
	logic [31:0] lcgState;
	logic refActive;
	logic refTriggered;
	int refCount;
	int strobeIndex;
	int activeMode;
	int armAt;
	accelSum_t refSum;

	accelCommandBridge dut (.*);

	always #5 CLOCK_50 = ~CLOCK_50;

	// ==========================================================
	// helpers and reference model
	// ==========================================================
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int magnitudeOf(accelSample_t s);
		int v;
		v = int'(s);	// sign extended
		return (v < 0) ? -v : v;
	endfunction

	function automatic accelSample_t pickSample(logic [31:0] rnd);
		if (activeMode == MODE_QUIET && strobeIndex < 12) begin
			return accelSample_t'(int'(rnd[23:16] % 8'd31) - 15);	// -15 .. 15
		end
		if (activeMode == MODE_EXTREME) begin
			case (rnd[17:16])
				2'd0: return accelSample_t'(8'h80);
				2'd1: return accelSample_t'(8'h7f);
				2'd2: return accelSample_t'(8'hf0);	// -16, right at trigger
				default: return accelSample_t'(8'h0f);
			endcase
		end
		return accelSample_t'(rnd[23:16]);
	endfunction

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkId(input string testName, input cmdId_t expected, input cmdId_t actual);
		if (actual !== expected) begin
			stopOnFailure($sformatf("Error %s: expected id %0d, actual %0d",
				testName, expected, actual));
		end
	endtask

	task automatic checkSum(input string testName, input accelSum_t expected,
			input accelSum_t actual);
		if (actual !== expected) begin
			stopOnFailure($sformatf("Error %s: expected sum %0d, actual %0d",
				testName, expected, actual));
		end
	endtask

	// trigger sample skipped, then SAMPLE_COUNT magnitudes added
	task automatic modelSample(input accelSample_t s);
		int mag;
		mag = magnitudeOf(s);
		strobeIndex++;
		if (!refTriggered) begin
			refTriggered = (mag >= dut.TRIGGER_LEVEL);
		end else begin
			refSum = refSum + accelSum_t'(mag);
			refCount++;
			if (refCount == dut.SAMPLE_COUNT) begin
				expSums.push_back(refSum);
				refActive = 1'b0;	// window closed, strobes stop
			end
		end
	endtask

	task automatic driveHostFifo();
		inEmpty = (hostQ.size() == 0);
		if (hostQ.size() != 0) begin
			inData = hostQ[0];	// show-ahead head word
		end else begin
			inData = '0;
		end
	endtask

	// ==========================================================
	// one clock cycle, all inputs driven on the falling edge
	// ==========================================================
	task automatic stepCycle();
		logic [31:0] rnd;
		logic strobe;
		@(negedge CLOCK_50);
		cycleCount++;
		if (readSeen) begin
			if (hostQ.size() == 0) begin
				stopOnFailure("DUT read from an empty host FIFO");
			end else begin
				void'(hostQ.pop_front());
				popCount++;
			end
			if (armPops.size() != 0 && popCount == armPops[0]) begin
				void'(armPops.pop_front());
				activeMode = armModes.pop_front();
				refActive = 1'b1;
				refTriggered = 1'b0;
				refCount = 0;
				refSum = '0;
				strobeIndex = 0;
				armAt = cycleCount + 4;	// summer is in its arm state by then
			end
		end
		readSeen = inRead;
		driveHostFifo();
		if (outWrite) begin
			respQ.push_back(outData);
		end
		case (bpMode)
			BP_PULSED: outFull = (cycleCount % 5) < 2;
			BP_LONG: outFull = (cycleCount % 16) < 11;
			default: outFull = 1'b0;
		endcase
		rnd = nextRandom();
		strobe = refActive && (cycleCount >= armAt) && (cycleCount % 4 == 0);
		if (strobe) begin
			accelSample = pickSample(rnd);
			modelSample(accelSample);
		end else begin
			accelSample = accelSample_t'(rnd[15:8]);	// present but not strobed
		end
		sampleStrobe = strobe;
	endtask

	task automatic setRow(input int i, input string name, input cmdId_t id,
			input fifoWord_t payload, input int mode, input int bp, input logic queued);
		rowName[i] = name;
		rowId[i] = id;
		rowPayload[i] = payload;
		rowMode[i] = mode;
		rowBp[i] = bp;
		rowQueued[i] = queued;
	endtask

	task automatic pushCommand(input int r);
		hostQ.push_back(rowId[r]);
		pushCount++;
		if (rowId[r] == CMD_ACCEL) begin
			hostQ.push_back(rowPayload[r]);	// dropped by the DUT
			pushCount++;
			armPops.push_back(pushCount);
			armModes.push_back(rowMode[r]);
		end
	endtask

	// fills the FIFO with one row or a queued run, then checks every response
	task automatic applyGroup(input int first, output int nextRow);
		int r;
		int i;
		string names [$];
		cmdId_t ids [$];
		cmdId_t gotId;
		accelSum_t gotSum;
		accelSum_t want;
		r = first;
		do begin
			pushCommand(r);
			names.push_back(rowName[r]);
			ids.push_back(rowId[r]);
			bpMode = rowBp[r];
			r++;
		end while (rowQueued[r-1] && r < NUM_ROWS);
		nextRow = r;
		driveHostFifo();
		while (respQ.size() < 2 * ids.size()) begin
			stepCycle();
		end
		for (i = 0; i < ids.size(); i++) begin
			gotId = respQ.pop_front();
			gotSum = respQ.pop_front();
			checkId(names[i], ids[i], gotId);
			if (ids[i] != CMD_ACCEL) begin
				want = '0;
			end else if (expSums.size() == 0) begin
				stopOnFailure($sformatf("%s: accel response came before the window closed",
					names[i]));
			end else begin
				want = expSums.pop_front();
			end
			checkSum(names[i], want, gotSum);
		end
		if (popCount != pushCount) begin
			stopOnFailure($sformatf("%s: DUT left %0d host words unread",
				names[0], pushCount - popCount));
		end
	endtask

	// ==========================================================
	// main flow
	// ==========================================================
	initial begin : mainFlow
		int row;
		CLOCK_50 = 1'b0;
		master_reset = 1'b1;
		inEmpty = 1'b1;
		inData = '0;
		outFull = 1'b0;
		accelSample = '0;
		sampleStrobe = 1'b0;
		lcgState = 32'h06c8_59b6;
		pushCount = 0;
		popCount = 0;
		cycleCount = 0;
		bpMode = BP_NONE;
		readSeen = 1'b0;
		refActive = 1'b0;
		armAt = 0;
		//     row  name                 id          payload        samples       outFull    queued
		setRow(0, "accelRandom",       CMD_ACCEL, 32'hdead_beef, MODE_RANDOM,  BP_NONE,   1'b0);
		setRow(1, "accelQuietStart",   CMD_ACCEL, 32'd10,        MODE_QUIET,   BP_NONE,   1'b0);
		setRow(2, "unknownSeven",      32'd7,     32'd0,         MODE_RANDOM,  BP_NONE,   1'b0);
		setRow(3, "accelBackPressure", CMD_ACCEL, 32'h0000_0001, MODE_EXTREME, BP_PULSED, 1'b0);
		setRow(4, "unknownLongFull",   32'hff,    32'd0,         MODE_RANDOM,  BP_LONG,   1'b0);
		setRow(5, "queuedUnknown",     32'd7,     32'd0,         MODE_RANDOM,  BP_PULSED, 1'b1);
		setRow(6, "queuedAccel",       CMD_ACCEL, 32'h1234_5678, MODE_QUIET,   BP_PULSED, 1'b1);
		setRow(7, "queuedLast",        32'd99,    32'd0,         MODE_RANDOM,  BP_PULSED, 1'b0);
		repeat (5) stepCycle();
		master_reset = 1'b0;
		row = 0;
		while (row < NUM_ROWS) begin
			applyGroup(row, row);
		end
		repeat (20) stepCycle();	// no stray writes after the last response
		if (respQ.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			stopOnFailure("DUT wrote response words with no command behind them");
		end
	end

	// time limit from the table length and the window size
	initial begin : watchdog
		int limitNs;
		limitNs = NUM_ROWS * (dut.SAMPLE_COUNT + 20) * 4 * 20;
		#(limitNs);
		stopOnFailure($sformatf("Watchdog expired after %0d ns, the run did not finish",
			limitNs));
	end

endmodule

//--- accelCommandBridge.f
hdl/accelBridgePkg.sv
hdl/hpsCommandReader.sv
hdl/accelSampleSummer.sv
hdl/commandSequencer.sv
hdl/hpsResponseWriter.sv
hdl/accelCommandBridge.sv
bench/accelCommandBridge_checker.sv
bench/accelCommandBridge_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the accelCommandBridge regression with Verilator.
# Exit status is 0 only when the log holds no failure message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module accelCommandBridge_tb \
	-f accelCommandBridge.f \
	--Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi
if [ $SIM_STATUS -ne 0 ]; then
	echo "simulation exited with status $SIM_STATUS, see $LOG"
	exit 1
fi

exit 0
